// ==== lsu_settings.svh ====
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// bus widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32  // four byte lanes

// transaction id width, also the bid/awid/arid width
`define LSU_ID_W 4

// fixed AXI4 field values, every transaction is one beat
`define LSU_BURST_INCR 2'b01  // INCR
`define LSU_LEN_SINGLE 8'h00  // len = beats - 1

`endif

// ==== lsu_pkg.sv ====
`default_nettype none

`include "lsu_settings.svh"

package lsu_pkg;

    typedef logic [`LSU_ADDR_W-1:0]   addr_t;    // byte address
    typedef logic [`LSU_DATA_W-1:0]   word_t;
    typedef logic [`LSU_DATA_W/8-1:0] strb_t;    // one bit per byte lane
    typedef logic [`LSU_ID_W-1:0]     axi_id_t;

    // encoded as AXI size, so a request size goes straight to awsize/arsize
    typedef enum logic [2:0] {
        SIZE_BYTE = 3'd0,
        SIZE_HALF = 3'd1,
        SIZE_WORD = 3'd2
    } access_size_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,  // exclusive ok, not expected here
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_t;

endpackage

`default_nettype wire

// ==== lsu_store_align.sv ====
`timescale 1ns/10ps
`default_nettype none

// places store data in its byte lane(s) and builds wstrb
// purely combinational, fed straight from the request
module lsu_store_align (
    input  lsu_pkg::access_size_t size,
    input  logic [1:0]            offset,      // addr[1:0]
    input  lsu_pkg::word_t        wdata,       // data from execute, low aligned
    output lsu_pkg::strb_t        strb,
    output lsu_pkg::word_t        lane_wdata
);

    logic [4:0] byte_shift;  // offset in bits

    assign byte_shift = {offset, 3'b000};

    always_comb begin
        // unused lanes stay zero
        strb       = '0;
        lane_wdata = '0;
        case (size)
            lsu_pkg::SIZE_BYTE: begin
                strb       = 4'b0001 << offset;
                lane_wdata = {24'b0, wdata[7:0]} << byte_shift;
            end
            lsu_pkg::SIZE_HALF: begin
                // offset[0] is always 0 for an aligned half
                if (offset[1]) begin
                    strb       = 4'b1100;
                    lane_wdata = {wdata[15:0], 16'b0};  // upper half
                end else begin
                    strb       = 4'b0011;
                    lane_wdata = {16'b0, wdata[15:0]};
                end
            end
            lsu_pkg::SIZE_WORD: begin
                strb       = 4'b1111;  // whole word
                lane_wdata = wdata;
            end
            default: begin
                strb       = '0;  // unknown size writes nothing
                lane_wdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== lsu_load_align.sv ====
`timescale 1ns/10ps
`default_nettype none

// picks the addressed lane out of the R beat and extends it
// result is registered, valid the cycle after load_beat
module lsu_load_align (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  load_beat,    // R handshake this cycle
    input  lsu_pkg::word_t        rdata,
    input  lsu_pkg::access_size_t size,
    input  logic [1:0]            offset,
    input  logic                  is_unsigned,
    output lsu_pkg::word_t        load_data
);

    logic [7:0]     byte_lane;
    logic [15:0]    half_lane;
    logic           fill;        // extension bit
    lsu_pkg::word_t extended;

    assign byte_lane = rdata[{offset, 3'b000} +: 8];
    assign half_lane = offset[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        fill     = 1'b0;
        extended = rdata;  // word passes as is
        case (size)
            lsu_pkg::SIZE_BYTE: begin
                fill     = !is_unsigned && byte_lane[7];  // lb vs lbu
                extended = {{24{fill}}, byte_lane};
            end
            lsu_pkg::SIZE_HALF: begin
                fill     = !is_unsigned && half_lane[15];  // lh vs lhu
                extended = {{16{fill}}, half_lane};
            end
            default: begin
                fill     = 1'b0;
                extended = rdata;
            end
        endcase
    end

    // holds until the next load beat
    always_ff @(posedge clock) begin
        if (reset) begin
            load_data <= '0;
        end else if (load_beat) begin
            load_data <= extended;
        end
    end

endmodule

`default_nettype wire

// ==== lsu_axi_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_settings.svh"

// captures one request and runs it as a single-beat AXI4 read or write
// load:  IDLE -> READ_ADDR -> READ_DATA -> FINISH
// store: IDLE -> WRITE_ADDR -> WRITE_DATA -> WRITE_RESP -> FINISH
module lsu_axi_fsm (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  req,           // one-cycle strobe
    input  logic                  req_write,
    input  lsu_pkg::addr_t        req_addr,
    input  lsu_pkg::access_size_t req_size,
    input  logic                  req_unsigned,
    input  lsu_pkg::strb_t        store_strb,    // already lane placed
    input  lsu_pkg::word_t        store_wdata,

    output logic                  busy,
    output logic                  done,
    output logic                  done_error,

    output logic                  load_beat,
    output lsu_pkg::access_size_t load_size,
    output logic [1:0]            load_offset,
    output logic                  load_unsigned,

    output logic                  awvalid,
    input  logic                  awready,
    output lsu_pkg::addr_t        awaddr,
    output lsu_pkg::axi_id_t      awid,
    output logic [7:0]            awlen,
    output logic [2:0]            awsize,
    output logic [1:0]            awburst,

    output logic                  wvalid,
    input  logic                  wready,
    output lsu_pkg::word_t        wdata,
    output lsu_pkg::strb_t        wstrb,
    output logic                  wlast,

    input  logic                  bvalid,
    output logic                  bready,
    input  logic [1:0]            bresp,
    input  lsu_pkg::axi_id_t      bid,

    output logic                  arvalid,
    input  logic                  arready,
    output lsu_pkg::addr_t        araddr,
    output lsu_pkg::axi_id_t      arid,
    output logic [7:0]            arlen,
    output logic [2:0]            arsize,
    output logic [1:0]            arburst,

    input  logic                  rvalid,
    output logic                  rready,
    input  logic [1:0]            rresp
);

    typedef enum logic [2:0] {
        IDLE,
        WRITE_ADDR,
        WRITE_DATA,
        WRITE_RESP,
        READ_ADDR,
        READ_DATA,
        FINISH       // done pulse, can take the next req
    } state_t;

    state_t                state;
    state_t                next_state;

    lsu_pkg::addr_t        saved_addr;
    lsu_pkg::word_t        saved_wdata;
    lsu_pkg::strb_t        saved_strb;
    lsu_pkg::access_size_t saved_size;
    logic                  saved_unsigned;
    lsu_pkg::axi_id_t      curr_id;
    logic                  err_q;        // result of the last response

    logic accept;
    logic b_fire;
    logic r_fire;
    logic b_err;
    logic r_err;

    // FINISH counts as free so back-to-back requests lose no cycle
    assign busy   = (state != IDLE) && (state != FINISH);
    assign accept = req && !busy;
    assign b_fire = bvalid && bready;
    assign r_fire = rvalid && rready;

    // rid is not compared, only the write side checks the id
    assign b_err = (bresp != lsu_pkg::RESP_OKAY) || (bid != curr_id);
    assign r_err = rresp != lsu_pkg::RESP_OKAY;

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= IDLE;
            curr_id <= '0;  // first request gets id 1
            err_q   <= 1'b0;
        end else begin
            state <= next_state;
            if (accept) begin
                curr_id <= curr_id + lsu_pkg::axi_id_t'(1);  // wraps at 16
            end
            if (b_fire) begin
                err_q <= b_err;
            end else if (r_fire) begin
                err_q <= r_err;
            end
        end
    end

    // request payload, held for the whole transaction
    always_ff @(posedge clock) begin
        if (accept) begin
            saved_addr     <= req_addr;
            saved_wdata    <= store_wdata;
            saved_strb     <= store_strb;
            saved_size     <= req_size;
            saved_unsigned <= req_unsigned;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE, FINISH: begin
                if (accept) begin
                    next_state = req_write ? WRITE_ADDR : READ_ADDR;
                end else begin
                    next_state = IDLE;
                end
            end
            WRITE_ADDR: if (awready) next_state = WRITE_DATA;
            WRITE_DATA: if (wready)  next_state = WRITE_RESP;
            WRITE_RESP: if (bvalid)  next_state = FINISH;
            READ_ADDR:  if (arready) next_state = READ_DATA;
            READ_DATA:  if (rvalid)  next_state = FINISH;
            default:    next_state = IDLE;
        endcase
    end

    // handshakes straight from state, stable until the transfer
    assign awvalid = state == WRITE_ADDR;
    assign wvalid  = state == WRITE_DATA;
    assign bready  = state == WRITE_RESP;
    assign arvalid = state == READ_ADDR;
    assign rready  = state == READ_DATA;

    assign done       = state == FINISH;
    assign done_error = done && err_q;

    assign awaddr  = saved_addr;
    assign awid    = curr_id;
    assign awlen   = `LSU_LEN_SINGLE;
    assign awsize  = saved_size;      // size code is the AXI encoding
    assign awburst = `LSU_BURST_INCR;

    assign wdata = saved_wdata;
    assign wstrb = saved_strb;
    assign wlast = 1'b1;  // single beat

    assign araddr  = saved_addr;
    assign arid    = curr_id;
    assign arlen   = `LSU_LEN_SINGLE;
    assign arsize  = saved_size;
    assign arburst = `LSU_BURST_INCR;

    // lane info for the load aligner
    assign load_beat     = r_fire;
    assign load_size     = saved_size;
    assign load_offset   = saved_addr[1:0];
    assign load_unsigned = saved_unsigned;

endmodule

`default_nettype wire

// ==== lsu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

// load-store unit, execute-side strobe in, single-beat AXI4 out
module lsu_top (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  req,
    input  logic                  req_write,
    input  lsu_pkg::addr_t        req_addr,
    input  lsu_pkg::word_t        req_wdata,
    input  lsu_pkg::access_size_t req_size,
    input  logic                  req_unsigned,
    output logic                  busy,
    output logic                  done,
    output logic                  done_error,
    output lsu_pkg::word_t        load_data,

    output logic                  awvalid,
    input  logic                  awready,
    output lsu_pkg::addr_t        awaddr,
    output lsu_pkg::axi_id_t      awid,
    output logic [7:0]            awlen,
    output logic [2:0]            awsize,
    output logic [1:0]            awburst,

    output logic                  wvalid,
    input  logic                  wready,
    output lsu_pkg::word_t        wdata,
    output lsu_pkg::strb_t        wstrb,
    output logic                  wlast,

    input  logic                  bvalid,
    output logic                  bready,
    input  logic [1:0]            bresp,
    input  lsu_pkg::axi_id_t      bid,

    output logic                  arvalid,
    input  logic                  arready,
    output lsu_pkg::addr_t        araddr,
    output lsu_pkg::axi_id_t      arid,
    output logic [7:0]            arlen,
    output logic [2:0]            arsize,
    output logic [1:0]            arburst,

    input  logic                  rvalid,
    output logic                  rready,
    input  lsu_pkg::word_t        rdata,
    input  logic [1:0]            rresp
);

    lsu_pkg::strb_t        store_strb;   // from the aligner, captured by the FSM
    lsu_pkg::word_t        store_wdata;
    logic                  load_beat;
    lsu_pkg::access_size_t load_size;
    logic [1:0]            load_offset;
    logic                  load_unsigned;

    // works on the live request, FSM latches the result on accept
    lsu_store_align u_store_align (
        .size       (req_size),
        .offset     (req_addr[1:0]),
        .wdata      (req_wdata),
        .strb       (store_strb),
        .lane_wdata (store_wdata)
    );

    // every FSM port has the same name at this level
    lsu_axi_fsm u_axi_fsm (.*);

    lsu_load_align u_load_align (
        .clock       (clock),
        .reset       (reset),
        .load_beat   (load_beat),
        .rdata       (rdata),
        .size        (load_size),
        .offset      (load_offset),
        .is_unsigned (load_unsigned),
        .load_data   (load_data)
    );

endmodule

`default_nettype wire

// ==== tb_axi_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

// single-outstanding AXI4 slave, byte memory, optional random ready stalls
// top address byte EE answers SLVERR and is never written
module tb_axi_mem (
    input  logic                clock,
    input  logic                reset,
    input  logic                stall_mode,   // 0 to 3 cycle ready delays
    input  logic                awvalid,
    output logic                awready,
    input  lsu_pkg::addr_t      awaddr,
    input  lsu_pkg::axi_id_t    awid,
    input  logic                wvalid,
    output logic                wready,
    input  lsu_pkg::word_t      wdata,
    input  lsu_pkg::strb_t      wstrb,
    output logic                bvalid,
    input  logic                bready,
    output logic [1:0]          bresp,
    output lsu_pkg::axi_id_t    bid,
    input  logic                arvalid,
    output logic                arready,
    input  lsu_pkg::addr_t      araddr,
    output logic                rvalid,
    input  logic                rready,
    output lsu_pkg::word_t      rdata,
    output logic [1:0]          rresp
);

    logic [7:0]       mem [lsu_pkg::addr_t];  // sparse, unwritten bytes read the fill
    integer           seed;
    logic [1:0]       wphase;                 // 0 aw, 1 w, 2 b
    logic [1:0]       wcnt;
    logic             rphase;                 // 0 ar, 1 r
    logic [1:0]       rcnt;
    lsu_pkg::addr_t   w_addr;
    lsu_pkg::axi_id_t w_id;
    lsu_pkg::addr_t   r_addr;

    initial seed = 32'h244fb670;

    function automatic logic [1:0] pick_delay();
        return stall_mode ? 2'($random(seed)) : 2'd0;
    endfunction

    // fill pattern mixes every address byte
    function automatic logic [7:0] fill_byte(lsu_pkg::addr_t a);
        return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'ha5;
    endfunction

    function automatic lsu_pkg::word_t read_word(lsu_pkg::addr_t a);
        lsu_pkg::addr_t ba;
        lsu_pkg::word_t w;
        for (int i = 0; i < 4; i++) begin
            ba = {a[31:2], 2'b00} + lsu_pkg::addr_t'(i);
            w[8*i +: 8] = mem.exists(ba) ? mem[ba] : fill_byte(ba);
        end
        return w;
    endfunction

    // write side: AW, then W, then B
    always @(posedge clock) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= lsu_pkg::RESP_OKAY;
            bid     <= '0;
            wphase  <= 2'd0;
            wcnt    <= 2'd0;
        end else begin
            case (wphase)
                2'd0: begin
                    if (awvalid && awready) begin
                        awready <= 1'b0;
                        w_addr  <= awaddr;
                        w_id    <= awid;   // echoed on bid
                        wphase  <= 2'd1;
                        wcnt    <= pick_delay();
                    end else if (awvalid && wcnt == 2'd0) begin
                        awready <= 1'b1;
                    end else if (awvalid) begin
                        wcnt <= wcnt - 2'd1;  // stall
                    end
                end
                2'd1: begin
                    if (wvalid && wready) begin
                        if (w_addr[31:24] != 8'hEE) begin
                            for (int i = 0; i < 4; i++) begin
                                if (wstrb[i]) begin
                                    mem[{w_addr[31:2], 2'b00} + lsu_pkg::addr_t'(i)] =
                                        wdata[8*i +: 8];
                                end
                            end
                        end
                        wready <= 1'b0;
                        wphase <= 2'd2;
                        wcnt   <= pick_delay();
                    end else if (wvalid && wcnt == 2'd0) begin
                        wready <= 1'b1;
                    end else if (wvalid) begin
                        wcnt <= wcnt - 2'd1;
                    end
                end
                2'd2: begin
                    if (bvalid && bready) begin
                        bvalid <= 1'b0;
                        wphase <= 2'd0;
                        wcnt   <= pick_delay();
                    end else if (!bvalid && wcnt == 2'd0) begin
                        bvalid <= 1'b1;
                        bresp  <= (w_addr[31:24] == 8'hEE) ? lsu_pkg::RESP_SLVERR
                                                           : lsu_pkg::RESP_OKAY;
                        bid    <= w_id;
                    end else if (!bvalid) begin
                        wcnt <= wcnt - 2'd1;
                    end
                end
                default: wphase <= 2'd0;
            endcase
        end
    end

    // read side: AR, then R
    always @(posedge clock) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= lsu_pkg::RESP_OKAY;
            rphase  <= 1'b0;
            rcnt    <= 2'd0;
        end else if (!rphase) begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                r_addr  <= araddr;
                rphase  <= 1'b1;
                rcnt    <= pick_delay();
            end else if (arvalid && rcnt == 2'd0) begin
                arready <= 1'b1;
            end else if (arvalid) begin
                rcnt <= rcnt - 2'd1;
            end
        end else begin
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                rphase <= 1'b0;
                rcnt   <= pick_delay();
            end else if (!rvalid && rcnt == 2'd0) begin
                rvalid <= 1'b1;
                if (r_addr[31:24] == 8'hEE) begin
                    rdata <= '0;  // error region
                    rresp <= lsu_pkg::RESP_SLVERR;
                end else begin
                    rdata <= read_word(r_addr);  // whole word, lanes fixed
                    rresp <= lsu_pkg::RESP_OKAY;
                end
            end else if (!rvalid) begin
                rcnt <= rcnt - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== lsu_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

// protocol and request rules, bound into lsu_top
module lsu_checker (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  req,
    input  logic                  busy,
    input  lsu_pkg::addr_t        req_addr,
    input  lsu_pkg::access_size_t req_size,
    input  logic                  awvalid,
    input  logic                  awready,
    input  lsu_pkg::addr_t        awaddr,
    input  lsu_pkg::axi_id_t      awid,
    input  logic                  wvalid,
    input  logic                  wready,
    input  lsu_pkg::word_t        wdata,
    input  lsu_pkg::strb_t        wstrb,
    input  logic                  wlast,
    input  logic                  arvalid,
    input  logic                  arready,
    input  lsu_pkg::addr_t        araddr,
    input  lsu_pkg::axi_id_t      arid
);

    logic aligned;

    // byte always ok, half on even, word on multiple of 4
    assign aligned = (req_size == lsu_pkg::SIZE_BYTE) ||
                     (req_size == lsu_pkg::SIZE_HALF && !req_addr[0]) ||
                     (req_size == lsu_pkg::SIZE_WORD && req_addr[1:0] == 2'b00);

    a_aw_hold: assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awid))
        else $error("awvalid dropped or AW payload changed before awready");

    a_w_hold: assert property (@(posedge clock) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else $error("wvalid dropped or W payload changed before wready");

    a_ar_hold: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
        else $error("arvalid dropped or AR payload changed before arready");

    a_req_idle: assert property (@(posedge clock) disable iff (reset) req |-> !busy)
        else $error("req issued while busy");

    a_req_aligned: assert property (@(posedge clock) disable iff (reset) req |-> aligned)
        else $error("misaligned request");

    a_wlast: assert property (@(posedge clock) disable iff (reset) wvalid |-> wlast)
        else $error("wlast low during a W beat");

endmodule

bind lsu_top lsu_checker u_checker (.*);

`default_nettype wire

// ==== tb_lsu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_lsu_top;

    logic                  clock;
    logic                  reset;
    logic                  stall_mode;
    logic                  req, req_write, req_unsigned;
    lsu_pkg::addr_t        req_addr;
    lsu_pkg::word_t        req_wdata;
    lsu_pkg::access_size_t req_size;
    logic                  busy, done, done_error;
    lsu_pkg::word_t        load_data;
    logic                  awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic                  arvalid, arready, rvalid, rready;
    lsu_pkg::addr_t        awaddr, araddr;
    lsu_pkg::axi_id_t      awid, arid, bid;
    logic [7:0]            awlen, arlen;
    logic [2:0]            awsize, arsize;
    logic [1:0]            awburst, arburst, bresp, rresp;
    lsu_pkg::word_t        wdata, rdata;
    lsu_pkg::strb_t        wstrb;

    integer                seed;
    lsu_pkg::axi_id_t      next_id;                // id the next request must carry
    logic [7:0]            model [lsu_pkg::addr_t];  // expected memory bytes

    lsu_top uut (.*);
    tb_axi_mem slave (.*);

    always #2 clock = ~clock;

    task automatic check_word(input lsu_pkg::word_t got, input lsu_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "word compare failed");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "flag compare failed");
        end
    endtask

    task automatic check_id(input lsu_pkg::axi_id_t got, input lsu_pkg::axi_id_t exp,
                            input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "id compare failed");
        end
    endtask

    // single beat means len 0, INCR burst is 2'b01
    task automatic check_ctrl(input logic [7:0] len, input logic [2:0] size,
                              input logic [1:0] burst, input logic [2:0] exp_size);
        if (len !== 8'h00 || size !== exp_size || burst !== 2'b01) begin
            $display("Mismatch at %0t: len %h size %0d burst %b expected 00 %0d 01",
                     $time, len, size, burst, exp_size);
            $display("TEST RESULT: FAIL");
            $fatal(1, "address control compare failed");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out at %0t waiting for %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    // enters and leaves 1 ns after a rising edge, also checks the address beat
    task automatic issue_request(input logic write, input lsu_pkg::addr_t addr,
                                 input lsu_pkg::access_size_t size, input logic is_unsigned,
                                 input lsu_pkg::word_t data);
        int         n;
        logic [2:0] exp_size;  // AXI size code, log2 of the byte count
        n = 0;
        while (busy && n < 200) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (busy) report_timeout("busy to fall");
        req          = 1'b1;
        req_write    = write;
        req_addr     = addr;
        req_size     = size;
        req_unsigned = is_unsigned;
        req_wdata    = data;
        @(posedge clock);
        #1;
        req = 1'b0;
        // busy and the address valid follow one cycle after req
        check_flag(busy, 1'b1, "busy after req");
        check_flag(awvalid, write, "awvalid after req");
        check_flag(arvalid, !write, "arvalid after req");
        case (size)
            lsu_pkg::SIZE_BYTE: exp_size = 3'd0;  // 1 byte
            lsu_pkg::SIZE_HALF: exp_size = 3'd1;  // 2 bytes
            default:            exp_size = 3'd2;  // 4 bytes
        endcase
        if (write) begin
            check_id(awid, next_id, "awid");
            check_ctrl(awlen, awsize, awburst, exp_size);
        end else begin
            check_id(arid, next_id, "arid");
            check_ctrl(arlen, arsize, arburst, exp_size);
        end
        next_id = next_id + lsu_pkg::axi_id_t'(1);  // wraps mod 16
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < 200) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (!done) report_timeout("done");
        check_flag(busy, 1'b0, "busy with done");  // free again in the done cycle
    endtask

    // store data comes low aligned, so byte i of data goes to addr + i
    task automatic model_store(input lsu_pkg::addr_t addr, input lsu_pkg::access_size_t size,
                               input lsu_pkg::word_t data);
        for (int i = 0; i < (1 << int'(size)); i++) begin
            model[addr + lsu_pkg::addr_t'(i)] = data[8*i +: 8];
        end
    endtask

    function automatic lsu_pkg::word_t expect_load(input lsu_pkg::addr_t addr,
                                                   input lsu_pkg::access_size_t size,
                                                   input logic is_unsigned);
        lsu_pkg::word_t v;
        int             nbytes;
        v      = '0;
        nbytes = 1 << int'(size);
        for (int i = 0; i < nbytes; i++) begin
            v[8*i +: 8] = model[addr + lsu_pkg::addr_t'(i)];
        end
        if (!is_unsigned && nbytes < 4 && v[8*nbytes-1]) begin
            for (int i = nbytes; i < 4; i++) begin
                v[8*i +: 8] = 8'hff;  // sign fill
            end
        end
        return v;
    endfunction

    task automatic run_store(input lsu_pkg::addr_t addr, input lsu_pkg::access_size_t size,
                             input lsu_pkg::word_t data);
        issue_request(1'b1, addr, size, 1'b0, data);
        wait_done();
        check_flag(done_error, 1'b0, "store done_error");
        model_store(addr, size, data);
    endtask

    task automatic run_load(input lsu_pkg::addr_t addr, input lsu_pkg::access_size_t size,
                            input logic is_unsigned);
        issue_request(1'b0, addr, size, is_unsigned, '0);
        wait_done();
        check_flag(done_error, 1'b0, "load done_error");
        check_word(load_data, expect_load(addr, size, is_unsigned), "load data");
    endtask

    task automatic test_word_roundtrip();
        run_store(32'h0000_1000, lsu_pkg::SIZE_WORD, 32'hdead_beef);
        run_load(32'h0000_1000, lsu_pkg::SIZE_WORD, 1'b0);
    endtask

    // word k gets a byte at offset k, other lanes keep the word store
    task automatic test_byte_lanes();
        lsu_pkg::addr_t base;
        for (int k = 0; k < 4; k++) begin
            base = lsu_pkg::addr_t'(32'h0000_2000 + 4 * k);
            run_store(base, lsu_pkg::SIZE_WORD, lsu_pkg::word_t'(32'h8a7b_6c5d + k));
            run_store(base + lsu_pkg::addr_t'(k), lsu_pkg::SIZE_BYTE,
                      k[0] ? 32'h5a5a_5a3c : 32'h5a5a_5ac3);  // upper bits ignored
        end
        for (int k = 0; k < 4; k++) begin
            base = lsu_pkg::addr_t'(32'h0000_2000 + 4 * k);
            for (int u = 0; u < 2; u++) begin
                for (int off = 0; off < 4; off++) begin
                    run_load(base + lsu_pkg::addr_t'(off), lsu_pkg::SIZE_BYTE, u[0]);
                end
                run_load(base, lsu_pkg::SIZE_HALF, u[0]);
                run_load(base + 32'd2, lsu_pkg::SIZE_HALF, u[0]);
            end
        end
    endtask

    task automatic test_random_stall();
        lsu_pkg::word_t        r;
        lsu_pkg::addr_t        addr;
        lsu_pkg::access_size_t size;
        stall_mode = 1'b1;
        for (int i = 0; i < 16; i++) begin  // known contents for the loads
            run_store(lsu_pkg::addr_t'(32'h0000_3000 + 4 * i), lsu_pkg::SIZE_WORD,
                      $random(seed));
        end
        for (int i = 0; i < 20; i++) begin
            r    = $random(seed);
            addr = 32'h0000_3000 + {26'b0, r[5:0]};
            size = r[8] ? lsu_pkg::SIZE_WORD : lsu_pkg::SIZE_BYTE;
            if (r[8]) addr[1:0] = 2'b00;
            if (r[9]) begin
                run_store(addr, size, $random(seed));
            end else begin
                run_load(addr, size, r[10]);
            end
        end
        stall_mode = 1'b0;
    endtask

    task automatic test_error_region();
        issue_request(1'b0, 32'hEE00_0010, lsu_pkg::SIZE_WORD, 1'b0, '0);
        wait_done();
        check_flag(done_error, 1'b1, "error region load done_error");
        issue_request(1'b1, 32'hEE00_0020, lsu_pkg::SIZE_WORD, 1'b0, 32'h1234_5678);
        wait_done();
        check_flag(done_error, 1'b1, "error region store done_error");
    endtask

    // enough back-to-back requests to wrap the 4-bit id, checked in issue_request
    task automatic test_id_wrap();
        for (int i = 0; i < 18; i++) begin
            if (i[0]) begin
                run_store(32'h0000_1004, lsu_pkg::SIZE_WORD, lsu_pkg::word_t'(i));
            end else begin
                run_load(32'h0000_1000, lsu_pkg::SIZE_WORD, 1'b0);
            end
        end
    endtask

    initial begin
        seed         = 32'h244fb670;
        clock        = 1'b0;
        reset        = 1'b1;
        stall_mode   = 1'b0;
        req          = 1'b0;
        req_write    = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        req_size     = lsu_pkg::SIZE_WORD;
        req_unsigned = 1'b0;
        next_id      = lsu_pkg::axi_id_t'(1);  // first request after reset
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        test_word_roundtrip();
        test_byte_lanes();
        test_random_stall();
        test_error_region();
        test_id_wrap();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== lsu_top.f ====
+incdir+.
lsu_pkg.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_axi_fsm.sv
lsu_top.sv
tb_axi_mem.sv
lsu_checker.sv
tb_lsu_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_lsu_top -f lsu_top.f -o sim_lsu

./obj_dir/sim_lsu > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "lsu simulation passed"
else
    echo "lsu simulation did not pass"
    exit 1
fi
